// File: ifetch_settings.svh
`ifndef IFETCH_SETTINGS_SVH
`define IFETCH_SETTINGS_SVH

// number of TLB entries, each mapping an even/odd page pair
`define TLB_NUM 16

// cache index taken from address bits 11 to 4
`define IDX_BITS 8

// byte offset inside a 16-byte line
`define OFF_BITS 4

// 32-bit words per line refill burst
`define BURST_BEATS 4

`endif

// File: ifetch_pkg.sv
`include "ifetch_settings.svh"

package ifetch_pkg;

    // virtual page pair number, address bits 31 to 13
    typedef logic [18:0] vpn2_t;

    // physical frame number, doubles as the cache tag
    typedef logic [19:0] pfn_t;

    typedef logic [7:0] asid_t;

    typedef logic [$clog2(`TLB_NUM)-1:0] tlb_idx_t;

    // 70 bits, even page first
    typedef struct packed {
        vpn2_t vpn2;
        asid_t asid;
        logic  g;
        pfn_t  pfn0;
        logic  v0;
        pfn_t  pfn1;
        logic  v1;
    } tlb_entry_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REFILL,
        DONE
    } icache_state_e;

    typedef enum logic [1:0] {
        AR_IDLE,
        AR_ADDR,
        AR_DATA
    } ar_state_e;

endpackage

// File: tlb_search_if.sv
interface tlb_search_if import ifetch_pkg::*; ();

    // request side
    vpn2_t vpn2;
    logic  odd_page;
    asid_t asid;

    // result side, found already includes the page valid bit
    logic  found;
    pfn_t  pfn;

    modport cache (
        output vpn2,
        output odd_page,
        output asid,
        input  found,
        input  pfn
    );

    modport search (
        input  vpn2,
        input  odd_page,
        input  asid,
        output found,
        output pfn
    );

endinterface

// File: refill_if.sv
interface refill_if;

    // line request, address is line aligned and physical
    logic        rd_req;
    logic [31:0] rd_addr;
    logic        rd_rdy;

    // returned beats, one word per ret_valid cycle
    logic        ret_valid;
    logic        ret_last;
    logic [31:0] ret_data;

    modport cache (
        output rd_req,
        output rd_addr,
        input  rd_rdy,
        input  ret_valid,
        input  ret_last,
        input  ret_data
    );

    modport bridge (
        input  rd_req,
        input  rd_addr,
        output rd_rdy,
        output ret_valid,
        output ret_last,
        output ret_data
    );

endinterface

// File: tlb.sv
`include "ifetch_settings.svh"

module tlb import ifetch_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        we,
    input  tlb_idx_t    w_index,
    input  tlb_entry_t  w_entry,
    tlb_search_if.search s
);

    tlb_entry_t          entries [`TLB_NUM];
    logic [`TLB_NUM-1:0] match;
    tlb_entry_t          sel;
    logic                sel_v;

    // small register file, cleared so no entry holds a valid page after reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `TLB_NUM; i++) begin
                entries[i] <= '0;
            end
        end else if (we) begin
            entries[w_index] <= w_entry;
        end
    end

    // parallel compare over all entries
    // an entry with neither page valid is treated as empty and never matches
    always_comb begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            match[i] = (entries[i].vpn2 == s.vpn2)
                     && (entries[i].g || (entries[i].asid == s.asid))
                     && (entries[i].v0 || entries[i].v1);
        end
    end

    // one-hot select, so an or-reduction is enough
    always_comb begin
        sel = '0;
        for (int i = 0; i < `TLB_NUM; i++) begin
            if (match[i]) begin
                sel = sel | entries[i];
            end
        end
    end

    // bit 12 of the address picks the odd page
    assign sel_v   = s.odd_page ? sel.v1 : sel.v0;
    assign s.found = (|match) && sel_v;
    assign s.pfn   = s.odd_page ? sel.pfn1 : sel.pfn0;

    // software must never load overlapping mappings
    a_single_match: assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0(match)
    );

endmodule

// File: icache.sv
`include "ifetch_settings.svh"

module icache import ifetch_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         req,
    input  logic [31:0]  addr,
    input  asid_t        asid,
    output logic         addr_ok,
    output logic         data_ok,
    output logic [31:0]  inst_rdata,
    output logic         tlb_exc,
    tlb_search_if.cache  ts,
    refill_if.cache      rf
);

    localparam int LINES  = 1 << `IDX_BITS;
    localparam int BEAT_W = $clog2(`BURST_BEATS);

    icache_state_e state;
    icache_state_e state_nxt;

    logic [31:0]       addr_q;
    pfn_t              pfn_q;
    logic [BEAT_W-1:0] beat_q;
    logic [1:0]        open_cnt;

    // line storage
    logic [31:0]       data_mem [LINES][`BURST_BEATS];
    pfn_t              tag_mem [LINES];
    logic [LINES-1:0]  line_valid;
    logic [31:0]       refill_buf [`BURST_BEATS];
    logic [31:0]       line_words [`BURST_BEATS];

    logic [`IDX_BITS-1:0] idx;
    logic [BEAT_W-1:0]    word_sel;
    logic                 tag_hit;
    logic                 lookup_hit;
    logic                 lookup_exc;
    logic                 accept;
    logic                 beat_fire;
    logic                 refill_fin;

    assign idx      = addr_q[`OFF_BITS +: `IDX_BITS];
    assign word_sel = addr_q[2 +: BEAT_W];

    // translate the registered address during LOOKUP
    assign ts.vpn2     = addr_q[31:13];
    assign ts.odd_page = addr_q[12];
    assign ts.asid     = asid;

    assign tag_hit    = line_valid[idx] && (tag_mem[idx] == ts.pfn);
    assign lookup_hit = (state == LOOKUP) && ts.found && tag_hit;
    assign lookup_exc = (state == LOOKUP) && !ts.found;

    // a new fetch may enter while the previous one is returning
    assign addr_ok = (state == IDLE) || lookup_hit || lookup_exc;
    assign accept  = req && addr_ok;

    assign data_ok    = lookup_hit || lookup_exc || (state == DONE);
    assign tlb_exc    = lookup_exc;
    assign inst_rdata = (state == DONE) ? refill_buf[word_sel] : data_mem[idx][word_sel];

    // line request toward the bridge
    assign rf.rd_req  = (state == MISS);
    assign rf.rd_addr = {pfn_q, idx, {`OFF_BITS{1'b0}}};

    assign beat_fire  = (state == REFILL) && rf.ret_valid;
    assign refill_fin = beat_fire && rf.ret_last;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP: begin
                if (lookup_hit || lookup_exc) begin
                    state_nxt = accept ? LOOKUP : IDLE;
                end else begin
                    state_nxt = MISS;
                end
            end
            MISS: begin
                if (rf.rd_rdy) begin
                    state_nxt = REFILL;
                end
            end
            REFILL: begin
                if (refill_fin) begin
                    state_nxt = DONE;
                end
            end
            DONE: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // beat counter restarts with each line request
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            beat_q <= '0;
        end else if (rf.rd_req && rf.rd_rdy) begin
            beat_q <= '0;
        end else if (beat_fire) begin
            beat_q <= beat_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            line_valid <= '0;
        end else if (refill_fin) begin
            line_valid[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= addr;
        end
        // keep the frame for the refill, the TLB may change meanwhile
        if (state == LOOKUP) begin
            pfn_q <= ts.pfn;
        end
    end

    // final beat goes straight into the line
    always_comb begin
        for (int k = 0; k < `BURST_BEATS; k++) begin
            line_words[k] = (BEAT_W'(k) == beat_q) ? rf.ret_data : refill_buf[k];
        end
    end

    always_ff @(posedge clk) begin
        if (beat_fire) begin
            refill_buf[beat_q] <= rf.ret_data;
        end
        if (refill_fin) begin
            tag_mem[idx] <= pfn_q;
            for (int k = 0; k < `BURST_BEATS; k++) begin
                data_mem[idx][k] <= line_words[k];
            end
        end
    end

    // fetches accepted but not yet answered
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            open_cnt <= '0;
        end else if (accept && !data_ok) begin
            open_cnt <= open_cnt + 2'd1;
        end else if (!accept && data_ok) begin
            open_cnt <= open_cnt - 2'd1;
        end
    end

    a_data_ok_owed: assert property (
        @(posedge clk) disable iff (!arst_n)
        data_ok |-> (open_cnt != 2'd0)
    );

endmodule

// File: axi_read_bridge.sv
module axi_read_bridge import ifetch_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    refill_if.bridge     rf,
    output logic [31:0]  araddr,
    output logic         arvalid,
    input  logic         arready,
    input  logic [31:0]  rdata,
    input  logic         rlast,
    input  logic         rvalid,
    output logic         rready
);

    ar_state_e   state;
    ar_state_e   state_nxt;
    logic [31:0] addr_q;

    // one burst at a time
    assign rf.rd_rdy = (state == AR_IDLE);

    assign araddr  = addr_q;
    assign arvalid = (state == AR_ADDR);
    assign rready  = (state == AR_DATA);

    // R beats pass through without a buffer, stalls follow rvalid
    assign rf.ret_valid = (state == AR_DATA) && rvalid;
    assign rf.ret_last  = rlast;
    assign rf.ret_data  = rdata;

    always_comb begin
        state_nxt = state;
        case (state)
            AR_IDLE: begin
                if (rf.rd_req) begin
                    state_nxt = AR_ADDR;
                end
            end
            AR_ADDR: begin
                if (arready) begin
                    state_nxt = AR_DATA;
                end
            end
            AR_DATA: begin
                if (rvalid && rlast) begin
                    state_nxt = AR_IDLE;
                end
            end
            default: begin
                state_nxt = AR_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= AR_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // line address held until the AR handshake
    always_ff @(posedge clk) begin
        if ((state == AR_IDLE) && rf.rd_req) begin
            addr_q <= rf.rd_addr;
        end
    end

    a_araddr_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        (arvalid && !arready) |=> (arvalid && $stable(araddr))
    );

endmodule

// File: ifetch_top.sv
module ifetch_top import ifetch_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,

    // fetch port
    input  logic        req,
    input  logic [31:0] addr,
    output logic        addr_ok,
    output logic        data_ok,
    output logic [31:0] inst_rdata,
    output logic        tlb_exc,

    // TLB control
    input  asid_t       asid,
    input  logic        tlb_we,
    input  tlb_idx_t    tlb_w_index,
    input  tlb_entry_t  tlb_w_entry,

    // AXI read, incr burst of 4 words with id 0
    output logic [31:0] araddr,
    output logic        arvalid,
    input  logic        arready,
    input  logic [31:0] rdata,
    input  logic        rlast,
    input  logic        rvalid,
    output logic        rready
);

    tlb_search_if ts_if ();
    refill_if     rf_if ();

    tlb u_tlb (
        .clk     (clk),
        .arst_n  (arst_n),
        .we      (tlb_we),
        .w_index (tlb_w_index),
        .w_entry (tlb_w_entry),
        .s       (ts_if.search)
    );

    icache u_icache (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (req),
        .addr       (addr),
        .asid       (asid),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .inst_rdata (inst_rdata),
        .tlb_exc    (tlb_exc),
        .ts         (ts_if.cache),
        .rf         (rf_if.cache)
    );

    axi_read_bridge u_bridge (
        .clk     (clk),
        .arst_n  (arst_n),
        .rf      (rf_if.bridge),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready)
    );

endmodule

// File: tb_axi_mem.sv
`include "ifetch_settings.svh"

module tb_axi_mem (
    input  logic        clk,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic        rlast,
    output logic        rvalid,
    input  logic        rready
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int BEATS    = `BURST_BEATS;
    localparam int MAX_WAIT = 3;

    logic [31:0] base;
    int          beat;
    int          ar_wait;
    int          r_wait;
    bit          busy;
    bit          ar_pend;
    bit          ar_fire;
    bit          r_fire;

    // every word depends on its whole byte address
    function automatic logic [31:0] mem_word(input logic [31:0] pa);
        return {pa[15:0], pa[31:16]} ^ (pa * 32'h9e3779b1) ^ 32'h5bd1e995;
    endfunction

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rdata   = '0;
        base    = '0;
        busy    = 1'b0;
        beat    = 0;
        ar_wait = 0;
        r_wait  = 0;
        forever begin
            // sample the handshakes mid-cycle
            @(negedge clk);
            ar_pend = arvalid && !arready;
            ar_fire = arvalid && arready;
            r_fire  = rvalid && rready;
            if (ar_fire) begin
                base = araddr;
            end
            @(posedge clk);
            #1;
            if (ar_fire) begin
                arready = 1'b0;
                ar_wait = $urandom_range(0, MAX_WAIT);
                busy    = 1'b1;
                beat    = 0;
                r_wait  = $urandom_range(0, MAX_WAIT);
            end else if (ar_pend && !busy) begin
                if (ar_wait == 0) begin
                    arready = 1'b1;
                end else begin
                    ar_wait--;
                end
            end
            if (r_fire) begin
                rvalid = 1'b0;
                rlast  = 1'b0;
                if (beat == BEATS - 1) begin
                    busy = 1'b0;
                end else begin
                    beat++;
                    r_wait = $urandom_range(0, MAX_WAIT);
                end
            end
            // next beat once its gap has run out
            if (busy && !rvalid) begin
                if (r_wait == 0) begin
                    rvalid = 1'b1;
                    rdata  = mem_word(base + 32'(beat * 4));
                    rlast  = (beat == BEATS - 1);
                end else begin
                    r_wait--;
                end
            end
        end
    end

endmodule

// File: tb_ifetch_top.sv
`include "ifetch_settings.svh"

module tb_ifetch_top import ifetch_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_RANDOM  = 300;
    localparam int NUM_FETCH   = NUM_RANDOM + 40;
    // worst refill with 3-cycle AR and beat gaps rounded up
    localparam int MISS_LAT    = 32;
    localparam int CYCLE_LIMIT = NUM_FETCH * MISS_LAT + 500;

    logic        clk;
    logic        arst_n;
    logic        req;
    logic [31:0] addr;
    logic        addr_ok;
    logic        data_ok;
    logic [31:0] inst_rdata;
    logic        tlb_exc;
    asid_t       asid;
    logic        tlb_we;
    tlb_idx_t    tlb_w_index;
    tlb_entry_t  tlb_w_entry;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic        rlast;
    logic        rvalid;
    logic        rready;

    tlb_entry_t shadow [`TLB_NUM];

    // one expectation per accepted fetch
    logic        exp_exc_q [$];
    logic [31:0] exp_word_q [$];
    int          exp_cyc_q [$];
    bit          exp_fast_q [$];

    // line address of the latest accepted fetch
    logic [31:0] line_addr = '0;

    string test_name = "reset";
    int    cycle = 0;
    int    ar_count = 0;
    int    arvalid_cycles = 0;
    int    resp_checks = 0;
    int    resp_errors = 0;
    int    main_checks = 0;
    int    main_errors = 0;
    int    chk_mark = 0;
    int    err_mark = 0;

    ifetch_top u_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (req),
        .addr        (addr),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .inst_rdata  (inst_rdata),
        .tlb_exc     (tlb_exc),
        .asid        (asid),
        .tlb_we      (tlb_we),
        .tlb_w_index (tlb_w_index),
        .tlb_w_entry (tlb_w_entry),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rlast       (rlast),
        .rvalid      (rvalid),
        .rready      (rready)
    );

    tb_axi_mem u_mem (
        .clk     (clk),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle == CYCLE_LIMIT) begin
            $display("timeout: run still busy after %0d cycles in test %s", cycle, test_name);
            $display("Checks failed");
            $finish;
        end
    end

    // same mixing as the memory model
    function automatic logic [31:0] mem_word(input logic [31:0] pa);
        return {pa[15:0], pa[31:16]} ^ (pa * 32'h9e3779b1) ^ 32'h5bd1e995;
    endfunction

    // expected result from the shadow TLB and the memory contents
    function automatic void translate(input logic [31:0] va, input asid_t cur,
                                      output logic exc, output logic [31:0] pa,
                                      output logic [31:0] word);
        logic hit;
        pfn_t pfn;
        hit = 1'b0;
        pfn = '0;
        for (int i = 0; i < `TLB_NUM; i++) begin
            if ((shadow[i].vpn2 == va[31:13]) && (shadow[i].g || (shadow[i].asid == cur))) begin
                if (va[12] && shadow[i].v1) begin
                    hit = 1'b1;
                    pfn = shadow[i].pfn1;
                end else if (!va[12] && shadow[i].v0) begin
                    hit = 1'b1;
                    pfn = shadow[i].pfn0;
                end
            end
        end
        exc  = !hit;
        pa   = {pfn, va[11:2], 2'b00};
        word = hit ? mem_word(pa) : 32'h0;
    endfunction

    function automatic tlb_entry_t make_entry(input vpn2_t vpn2, input asid_t id, input logic g,
                                              input pfn_t pfn0, input logic v0,
                                              input pfn_t pfn1, input logic v1);
        tlb_entry_t e;
        e.vpn2 = vpn2;
        e.asid = id;
        e.g    = g;
        e.pfn0 = pfn0;
        e.v0   = v0;
        e.pfn1 = pfn1;
        e.v1   = v1;
        return e;
    endfunction

    task automatic check_response();
        logic        e_exc;
        logic [31:0] e_word;
        int          e_cyc;
        bit          e_fast;
        resp_checks++;
        if (exp_exc_q.size() == 0) begin
            $display("%s: data_ok arrived with no fetch outstanding", test_name);
            resp_errors++;
            return;
        end
        e_exc  = exp_exc_q.pop_front();
        e_word = exp_word_q.pop_front();
        e_cyc  = exp_cyc_q.pop_front();
        e_fast = exp_fast_q.pop_front();
        if (tlb_exc !== e_exc) begin
            $display("[ERROR] %s: expected tlb_exc %0b, actual %0b", test_name, e_exc, tlb_exc);
            resp_errors++;
        end else if (!e_exc && (inst_rdata !== e_word)) begin
            $display("[ERROR] %s: expected %08h, actual %08h", test_name, e_word, inst_rdata);
            resp_errors++;
        end
        if (e_fast && (cycle != e_cyc + 1)) begin
            $display("%s: data_ok came %0d cycles after the accept instead of 1",
                     test_name, cycle - e_cyc);
            resp_errors++;
        end
    endtask

    // burst address must be the line of the fetch that missed
    task automatic check_burst_addr();
        main_checks++;
        if (araddr !== line_addr) begin
            $display("[ERROR] %s araddr: expected %08h, actual %08h",
                     test_name, line_addr, araddr);
            main_errors++;
        end
    endtask

    // compare process sampling mid-cycle
    always @(negedge clk) begin
        if (arst_n) begin
            if (arvalid) begin
                arvalid_cycles++;
            end
            if (arvalid && arready) begin
                ar_count++;
                check_burst_addr();
            end
            if (data_ok) begin
                check_response();
            end
        end
    end

    task automatic check_value(input string what, input int expected, input int actual);
        main_checks++;
        if (expected != actual) begin
            $display("[ERROR] %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
            main_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        chk_mark  = resp_checks + main_checks;
        err_mark  = resp_errors + main_errors;
    endtask

    task automatic finish_test();
        $display("test %-12s %0d checks, %0d errors", test_name,
                 resp_checks + main_checks - chk_mark, resp_errors + main_errors - err_mark);
    endtask

    task automatic write_tlb(input int idx, input tlb_entry_t e);
        tlb_we      = 1'b1;
        tlb_w_index = tlb_idx_t'(idx);
        tlb_w_entry = e;
        shadow[idx] = e;
        @(posedge clk);
        #1;
        tlb_we = 1'b0;
    endtask

    // fast marks a fetch known to answer 1 cycle after the accept
    task automatic fetch(input logic [31:0] va, input bit fast);
        logic        e_exc;
        logic [31:0] e_pa;
        logic [31:0] e_word;
        req  = 1'b1;
        addr = va;
        @(negedge clk);
        while (!addr_ok) begin
            @(negedge clk);
        end
        translate(va, asid, e_exc, e_pa, e_word);
        line_addr = {e_pa[31:`OFF_BITS], {`OFF_BITS{1'b0}}};
        exp_exc_q.push_back(e_exc);
        exp_word_q.push_back(e_word);
        exp_cyc_q.push_back(cycle);
        exp_fast_q.push_back(fast);
        @(posedge clk);
        #1;
        req = 1'b0;
    endtask

    task automatic drain();
        while (exp_exc_q.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        int          burst_base;
        int          av_base;
        int          region;
        logic [31:0] va;
        void'($urandom(44015));
        arst_n      = 1'b0;
        req         = 1'b0;
        addr        = '0;
        asid        = '0;
        tlb_we      = 1'b0;
        tlb_w_index = '0;
        tlb_w_entry = '0;
        for (int i = 0; i < `TLB_NUM; i++) begin
            shadow[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;

        start_test("reset");
        @(negedge clk);
        check_value("addr_ok", 1, 32'(addr_ok));
        check_value("data_ok", 0, 32'(data_ok));
        check_value("tlb_exc", 0, 32'(tlb_exc));
        check_value("arvalid", 0, 32'(arvalid));
        check_value("rready", 0, 32'(rready));
        @(posedge clk);
        #1;
        finish_test();

        start_test("miss_hit");
        write_tlb(0, make_entry(19'h00200, 8'h00, 1'b1, 20'h12345, 1'b1, 20'h0abcd, 1'b1));
        asid       = 8'h05;
        burst_base = ar_count;
        fetch(32'h0040_0018, 1'b0);
        drain();
        check_value("bursts after the miss", 1, ar_count - burst_base);
        for (int w = 0; w < 4; w++) begin
            fetch(32'h0040_0010 + w * 4, 1'b1);
        end
        drain();
        check_value("bursts after the hits", 1, ar_count - burst_base);
        finish_test();

        // both pages share index 2 and evict each other
        start_test("pages");
        burst_base = ar_count;
        fetch(32'h0040_0020, 1'b0);
        fetch(32'h0040_1020, 1'b0);
        fetch(32'h0040_1024, 1'b1);
        fetch(32'h0040_0024, 1'b0);
        drain();
        check_value("bursts", 3, ar_count - burst_base);
        finish_test();

        start_test("tlb_miss");
        write_tlb(1, make_entry(19'h00400, 8'h00, 1'b1, 20'h00777, 1'b1, 20'h00888, 1'b0));
        av_base = arvalid_cycles;
        fetch(32'h0080_1000, 1'b1);
        fetch(32'h0080_1ffc, 1'b1);
        fetch(32'h00c0_0000, 1'b1);
        fetch(32'h0500_0040, 1'b1);
        drain();
        check_value("arvalid cycles", 0, arvalid_cycles - av_base);
        finish_test();

        start_test("asid_global");
        write_tlb(2, make_entry(19'h01000, 8'h05, 1'b0, 20'h00333, 1'b1, 20'h00444, 1'b1));
        write_tlb(3, make_entry(19'h01800, 8'h09, 1'b1, 20'h00555, 1'b1, 20'h00000, 1'b0));
        fetch(32'h0200_0100, 1'b0);
        fetch(32'h0300_0204, 1'b0);
        drain();
        asid = 8'h06;
        fetch(32'h0200_0100, 1'b1);
        fetch(32'h0300_0204, 1'b1);
        fetch(32'h0200_1100, 1'b1);
        drain();
        asid = 8'h05;
        fetch(32'h0200_0100, 1'b1);
        drain();
        finish_test();

        start_test("random");
        for (int n = 0; n < NUM_RANDOM; n++) begin
            region = $urandom_range(0, 4);
            va     = (($urandom & 1) << 12) | (($urandom % 128) << 2);
            case (region)
                0: va = va | 32'h0040_0000;
                1: va = va | 32'h0080_0000;
                2: va = va | 32'h0200_0000;
                3: va = va | 32'h0300_0000;
                default: va = va | 32'h0500_0000;
            endcase
            if ($urandom_range(0, 3) == 0) begin
                @(posedge clk);
                #1;
            end
            fetch(va, 1'b0);
        end
        drain();
        finish_test();

        start_test("remap");
        write_tlb(0, make_entry(19'h00200, 8'h00, 1'b1, 20'h2468a, 1'b1, 20'h0abcd, 1'b1));
        burst_base = ar_count;
        fetch(32'h0040_0010, 1'b0);
        fetch(32'h0040_0010, 1'b1);
        drain();
        check_value("bursts", 1, ar_count - burst_base);
        finish_test();

        $display("total: %0d checks, %0d errors", resp_checks + main_checks,
                 resp_errors + main_errors);
        if (resp_errors + main_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: ifetch_top.f
+incdir+.
ifetch_pkg.sv
tlb_search_if.sv
refill_if.sv
tlb.sv
icache.sv
axi_read_bridge.sv
ifetch_top.sv
tb_axi_mem.sv
tb_ifetch_top.sv

// File: run.sh
#!/bin/sh
# build and run the instruction-fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_ifetch_top -Mdir obj_dir -f ifetch_top.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_ifetch_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1
